// File: src/rv32_mem_pkg.sv
/*
  shared sizes and types for the RV32 memory subsystem
  - word and address width, bytes per word
  - on-chip RAM depth, index width and address mask
  - load/store opcode enum (store bit + funct3)
  - memory controller arbiter states
*/
`default_nettype none

package rv32_mem_pkg;

  // data and address width
  localparam int WORD_W     = 32;
  localparam int WORD_BYTES = WORD_W / 8;

  // on-chip RAM depth in words
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // byte address range covered by the RAM
  localparam logic [WORD_W-1:0] ADDR_MASK = WORD_W'(RAM_WORDS * WORD_BYTES - 1);

  // bit 3 marks a store, bits 2:0 follow funct3
  // bits 1:0 give the access size, bit 2 the unsigned load
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } ls_op_t;

  // arbiter grant states
  typedef enum logic [1:0] {
    IDLE,
    SERVE_D,
    SERVE_I
  } arb_state_t;

endpackage

`default_nettype wire

// File: src/generic_bus_if.sv
/*
  generic bus interface
  cpu modport for requesters, generic_bus modport for responders
*/
`default_nettype none

interface generic_bus_if
  import rv32_mem_pkg::*;
();

  logic [WORD_W-1:0]     addr;
  logic [WORD_W-1:0]     wdata;
  logic [WORD_W-1:0]     rdata;
  logic                  ren;
  logic                  wen;
  logic [WORD_BYTES-1:0] byte_en;
  // high while no request or transfer still running
  logic                  busy;

  modport cpu (
    output addr, wdata, ren, wen, byte_en,
    input  rdata, busy
  );

  modport generic_bus (
    input  addr, wdata, ren, wen, byte_en,
    output rdata, busy
  );

endinterface

`default_nettype wire

// File: src/fetch_unit.sv
/*
  instruction fetch unit
  - program counter with redirect
  - sequential word reads on the generic bus
  - drop flag for a read made stale by a redirect
*/
`default_nettype none

module fetch_unit
  import rv32_mem_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic              fetch_en,
  input  logic              redirect,
  input  logic [WORD_W-1:0] redirect_pc,
  output logic [WORD_W-1:0] instr,
  output logic [WORD_W-1:0] instr_pc,
  output logic              instr_valid,
  generic_bus_if.cpu        bus
);

  logic [WORD_W-1:0] pc;
  logic [WORD_W-1:0] pc_next;
  // address of the read held on the bus
  logic [WORD_W-1:0] addr_q;
  logic              ren_q;
  logic              drop_q;
  logic              done;

  // read only, always the full word
  assign bus.addr    = addr_q;
  assign bus.ren     = ren_q;
  assign bus.wen     = 1'b0;
  assign bus.wdata   = '0;
  assign bus.byte_en = '1;

  assign done = ren_q && !bus.busy;

  // redirect wins, otherwise step past a reported word
  assign pc_next = redirect ? redirect_pc :
                   (done && !drop_q) ? pc + WORD_W'(WORD_BYTES) : pc;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc          <= '0;
      ren_q       <= 1'b0;
      drop_q      <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      pc          <= pc_next;
      if (done) begin
        ren_q  <= 1'b0;
        drop_q <= 1'b0;
        // stale word is swallowed here
        if (!drop_q && !redirect) begin
          instr_valid <= 1'b1;
          instr       <= bus.rdata;
          instr_pc    <= addr_q;
        end
      end else if (ren_q && redirect) begin
        drop_q <= 1'b1;
      end
      // next read issues back to back with the completion
      if (fetch_en && (!ren_q || done)) begin
        ren_q  <= 1'b1;
        addr_q <= pc_next;
      end
    end
  end

  // a posted read stays up, alone and at the same address, until busy drops
  a_read_held: assert property (@(posedge CLK) disable iff (!nRST)
    (bus.ren && bus.busy) |=> (bus.ren && !bus.wen && $stable(bus.addr)));

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
/*
  load/store unit
  - request latch and alignment check
  - store lane shift and byte enables
  - load lane select with sign or zero extension
*/
`default_nettype none

module load_store_unit
  import rv32_mem_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  input  logic              ls_req,
  input  ls_op_t            ls_op,
  input  logic [WORD_W-1:0] ls_addr,
  input  logic [WORD_W-1:0] ls_wdata,
  output logic [WORD_W-1:0] ls_rdata,
  output logic              ls_done,
  output logic              ls_misaligned,
  generic_bus_if.cpu        bus
);

  ls_op_t                op_q;
  logic [WORD_W-1:0]     addr_q;
  logic [WORD_W-1:0]     wdata_q;
  logic                  open_q;
  logic                  misaligned;
  logic                  xfer_done;
  logic [4:0]            lane_shift;
  logic [WORD_BYTES-1:0] size_mask;
  logic [WORD_W-1:0]     lane_data;
  logic [WORD_W-1:0]     load_val;

  // halfwords on even bytes, words on word boundaries
  always_comb begin
    case (ls_op)
      LH, LHU, SH: misaligned = ls_addr[0];
      LW, SW:      misaligned = |ls_addr[1:0];
      default:     misaligned = 1'b0;
    endcase
  end

  assign lane_shift = {addr_q[1:0], 3'b000};
  assign xfer_done  = open_q && !bus.busy;

  // byte enables from access size
  always_comb begin
    case (op_q[1:0])
      2'b00:   size_mask = 4'b0001;
      2'b01:   size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  assign bus.addr    = addr_q;
  assign bus.ren     = open_q && !op_q[3];
  assign bus.wen     = open_q && op_q[3];
  assign bus.wdata   = wdata_q << lane_shift;
  assign bus.byte_en = size_mask << addr_q[1:0];

  // pick the lane, then extend
  always_comb begin
    lane_data = bus.rdata >> lane_shift;
    case (op_q)
      LB:      load_val = {{(WORD_W-8){lane_data[7]}}, lane_data[7:0]};
      LBU:     load_val = {{(WORD_W-8){1'b0}}, lane_data[7:0]};
      LH:      load_val = {{(WORD_W-16){lane_data[15]}}, lane_data[15:0]};
      LHU:     load_val = {{(WORD_W-16){1'b0}}, lane_data[15:0]};
      default: load_val = lane_data;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      open_q        <= 1'b0;
      ls_done       <= 1'b0;
      ls_misaligned <= 1'b0;
    end else begin
      ls_done       <= xfer_done;
      ls_misaligned <= ls_req && misaligned;
      if (xfer_done) begin
        open_q <= 1'b0;
      end else if (ls_req && !misaligned) begin
        open_q <= 1'b1;
      end
    end
  end

  // request and result payload
  always_ff @(posedge CLK) begin
    if (ls_req && !open_q) begin
      op_q    <= ls_op;
      addr_q  <= ls_addr;
      wdata_q <= ls_wdata;
    end
    if (xfer_done && !op_q[3]) begin
      ls_rdata <= load_val;
    end
  end

  // core side issues one access at a time
  a_no_overlap: assert property (@(posedge CLK) disable iff (!nRST)
    ls_req |-> !open_q);

endmodule

`default_nettype wire

// File: src/memory_controller.sv
/*
  memory controller
  - registered grant, data side first
  - mux of the granted bus onto the RAM bus
  - address masked to the RAM range
*/
`default_nettype none

module memory_controller
  import rv32_mem_pkg::*;
(
  input  logic               CLK,
  input  logic               nRST,
  generic_bus_if.generic_bus i_bus,
  generic_bus_if.generic_bus d_bus,
  generic_bus_if.cpu         ram_bus
);

  arb_state_t        state;
  arb_state_t        state_n;
  logic              i_req;
  logic              d_req;
  logic [WORD_W-1:0] sel_addr;

  assign i_req = i_bus.ren || i_bus.wen;
  assign d_req = d_bus.ren || d_bus.wen;

  // grant held until the RAM finishes
  always_comb begin
    state_n = state;
    case (state)
      IDLE: begin
        if (d_req) begin
          state_n = SERVE_D;
        end else if (i_req) begin
          state_n = SERVE_I;
        end
      end
      SERVE_D, SERVE_I: begin
        if (!ram_bus.busy) begin
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_n;
    end
  end

  // request side mux, nothing reaches the RAM while idle
  always_comb begin
    sel_addr        = '0;
    ram_bus.wdata   = '0;
    ram_bus.ren     = 1'b0;
    ram_bus.wen     = 1'b0;
    ram_bus.byte_en = '0;
    case (state)
      SERVE_D: begin
        sel_addr        = d_bus.addr;
        ram_bus.wdata   = d_bus.wdata;
        ram_bus.ren     = d_bus.ren;
        ram_bus.wen     = d_bus.wen;
        ram_bus.byte_en = d_bus.byte_en;
      end
      SERVE_I: begin
        sel_addr        = i_bus.addr;
        ram_bus.wdata   = i_bus.wdata;
        ram_bus.ren     = i_bus.ren;
        ram_bus.wen     = i_bus.wen;
        ram_bus.byte_en = i_bus.byte_en;
      end
      default: ;
    endcase
  end

  assign ram_bus.addr = sel_addr & ADDR_MASK;

  // response side, waiting requester keeps busy high
  assign d_bus.busy  = (state == SERVE_D) ? ram_bus.busy : 1'b1;
  assign i_bus.busy  = (state == SERVE_I) ? ram_bus.busy : 1'b1;
  assign d_bus.rdata = (state == SERVE_D) ? ram_bus.rdata : '0;
  assign i_bus.rdata = (state == SERVE_I) ? ram_bus.rdata : '0;

  // a RAM completion only lands on a granted side still requesting
  a_done_to_grant: assert property (@(posedge CLK) disable iff (!nRST)
    !ram_bus.busy |-> ((state == SERVE_D && d_req) || (state == SERVE_I && i_req)));

endmodule

`default_nettype wire

// File: src/word_ram.sv
/*
  single-port word RAM
  - per-byte writes
  - one wait cycle, busy low on the second cycle of each transfer
*/
`default_nettype none

module word_ram
  import rv32_mem_pkg::*;
(
  input  logic               CLK,
  input  logic               nRST,
  generic_bus_if.generic_bus bus
);

  logic [WORD_W-1:0] mem [RAM_WORDS];
  logic [WORD_W-1:0] rdata_q;
  logic [RAM_AW-1:0] idx;
  // second cycle of a transfer
  logic              pending;

  assign idx = bus.addr[RAM_AW+1:2];

  assign bus.busy  = !pending;
  assign bus.rdata = rdata_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pending <= 1'b0;
    end else if (pending) begin
      pending <= 1'b0;
    end else if (bus.ren || bus.wen) begin
      pending <= 1'b1;
    end
  end

  // read sampled in the first cycle, shown in the second
  // write lands at the edge that closes the second
  always_ff @(posedge CLK) begin
    if (!pending && bus.ren) begin
      rdata_q <= mem[idx];
    end
    if (pending && bus.wen) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (bus.byte_en[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/riscv_mem_subsystem.sv
/*
  memory subsystem top level
  fetch unit and load/store unit sharing one word RAM
  through the data-first memory controller
*/
`default_nettype none

module riscv_mem_subsystem
  import rv32_mem_pkg::*;
(
  input  logic              CLK,
  input  logic              nRST,
  // fetch side
  input  logic              fetch_en,
  input  logic              redirect,
  input  logic [WORD_W-1:0] redirect_pc,
  output logic [WORD_W-1:0] instr,
  output logic [WORD_W-1:0] instr_pc,
  output logic              instr_valid,
  // data side
  input  logic              ls_req,
  input  ls_op_t            ls_op,
  input  logic [WORD_W-1:0] ls_addr,
  input  logic [WORD_W-1:0] ls_wdata,
  output logic [WORD_W-1:0] ls_rdata,
  output logic              ls_done,
  output logic              ls_misaligned
);

  // fetch, data and RAM buses
  generic_bus_if i_bus ();
  generic_bus_if d_bus ();
  generic_bus_if ram_bus ();

  fetch_unit fetch (
    .CLK         (CLK),
    .nRST        (nRST),
    .fetch_en    (fetch_en),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_valid (instr_valid),
    .bus         (i_bus.cpu)
  );

  load_store_unit lsu (
    .CLK           (CLK),
    .nRST          (nRST),
    .ls_req        (ls_req),
    .ls_op         (ls_op),
    .ls_addr       (ls_addr),
    .ls_wdata      (ls_wdata),
    .ls_rdata      (ls_rdata),
    .ls_done       (ls_done),
    .ls_misaligned (ls_misaligned),
    .bus           (d_bus.cpu)
  );

  memory_controller mc (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_bus   (i_bus.generic_bus),
    .d_bus   (d_bus.generic_bus),
    .ram_bus (ram_bus.cpu)
  );

  word_ram ram (
    .CLK  (CLK),
    .nRST (nRST),
    .bus  (ram_bus.generic_bus)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/*
  testbench clock and reset
  period 20 clock, reset low over the first 5 cycles
*/
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  // released on a falling edge, clear of the sampling edge
  initial begin
    nRST = 1'b0;
    repeat (5) @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_riscv_mem_subsystem.sv
/*
  testbench top for the RV32 memory subsystem
  - case file reader and dispatch
  - byte-wide reference memory with the load/store rules
  - load/store and fetch drivers with timeouts
  - value check task
*/
`default_nettype none

module tb_riscv_mem_subsystem
  import rv32_mem_pkg::*;
();

  // model copy of the RAM size, in bytes
  localparam int REF_BYTES   = 1024;
  localparam int FETCH_N     = 4;
  localparam int LS_LIMIT    = 40;
  localparam int FETCH_LIMIT = 200;

  logic        CLK;
  logic        nRST;
  logic        fetch_en;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] instr;
  logic [31:0] instr_pc;
  logic        instr_valid;
  logic        ls_req;
  ls_op_t      ls_op;
  logic [31:0] ls_addr;
  logic [31:0] ls_wdata;
  logic [31:0] ls_rdata;
  logic        ls_done;
  logic        ls_misaligned;
  logic [7:0]  ref_mem [REF_BYTES];

  tb_clock_gen clk_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  riscv_mem_subsystem uut (
    .CLK           (CLK),
    .nRST          (nRST),
    .fetch_en      (fetch_en),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .instr         (instr),
    .instr_pc      (instr_pc),
    .instr_valid   (instr_valid),
    .ls_req        (ls_req),
    .ls_op         (ls_op),
    .ls_addr       (ls_addr),
    .ls_wdata      (ls_wdata),
    .ls_rdata      (ls_rdata),
    .ls_done       (ls_done),
    .ls_misaligned (ls_misaligned)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // access size in bytes
  function automatic int op_size(input ls_op_t op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  // halfwords on even bytes, words on word boundaries
  function automatic logic misaligned_addr(input ls_op_t op, input logic [31:0] addr);
    return (addr & (op_size(op) - 1)) != 0;
  endfunction

  // little endian word at the aligned address
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [31:0] a;
    a = addr & (REF_BYTES - 4);
    return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
  endfunction

  function automatic logic [31:0] ref_load(input ls_op_t op, input logic [31:0] addr);
    logic [31:0] val;
    int i;
    val = '0;
    for (i = 0; i < op_size(op); i++) begin
      val[8*i +: 8] = ref_mem[(addr + i) & (REF_BYTES - 1)];
    end
    // sign extension for the signed loads only
    if (op == LB && val[7]) begin
      val[31:8] = '1;
    end else if (op == LH && val[15]) begin
      val[31:16] = '1;
    end
    return val;
  endfunction

  function automatic void ref_store(input ls_op_t op, input logic [31:0] addr,
                                    input logic [31:0] wdata);
    int i;
    for (i = 0; i < op_size(op); i++) begin
      ref_mem[(addr + i) & (REF_BYTES - 1)] = wdata[8*i +: 8];
    end
  endfunction

  // one ls_req, then wait for done or misaligned
  task automatic run_access(input ls_op_t op, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic misal, output logic [31:0] rdata);
    int    cyc;
    logic  seen;
    string pulse;
    if (misal) begin
      pulse = "ls_misaligned";
    end else begin
      pulse = "ls_done";
    end
    ls_req   = 1'b1;
    ls_op    = op;
    ls_addr  = addr;
    ls_wdata = wdata;
    seen     = 1'b0;
    cyc      = 0;
    rdata    = '0;
    while (!seen) begin
      @(negedge CLK);
      ls_req = 1'b0;
      cyc++;
      if (ls_done || ls_misaligned) begin
        seen = 1'b1;
        check("ls_misaligned", ls_misaligned, misal);
        check("ls_done", ls_done, !misal);
        rdata = ls_rdata;
      end else if (cyc >= LS_LIMIT) begin
        abort_run($sformatf("timeout: %s never pulsed for the access at %h", pulse, addr));
      end
    end
    // rejected access, no late completion either
    if (misal) begin
      repeat (6) begin
        @(negedge CLK);
        check("ls_done", ls_done, 1'b0);
      end
    end
  endtask

  task automatic pulse_redirect(input logic [31:0] target);
    redirect    = 1'b1;
    redirect_pc = target;
    fetch_en    = 1'b1;
    @(negedge CLK);
    redirect = 1'b0;
  endtask

  // count instr_valid pulses, pcs step by 4 from base
  task automatic collect_fetch(input logic [31:0] base, input int count);
    int          got;
    int          cyc;
    logic [31:0] pc_exp;
    got    = 0;
    cyc    = 0;
    pc_exp = base;
    while (got < count) begin
      @(negedge CLK);
      cyc++;
      if (instr_valid) begin
        check("instr_pc", instr_pc, pc_exp);
        check("instr", instr, ref_word(pc_exp));
        pc_exp = pc_exp + 4;
        got++;
        cyc = 0;
      end else if (cyc >= FETCH_LIMIT) begin
        abort_run($sformatf("timeout: instr_valid never pulsed for pc %h", pc_exp));
      end
    end
  endtask

  // mode 0 plain, 1 with loads alongside, 2 redirect mid-stream
  task automatic run_fetch(input logic [3:0] mode, input logic [31:0] start,
                           input logic [31:0] target);
    logic [31:0] rd;
    logic        seen;
    int          cyc;
    int          i;
    pulse_redirect(start);
    case (mode)
      4'h1: begin
        fork
          collect_fetch(start, FETCH_N);
          begin
            // data side wins the arbiter, fetch must still stay in order
            for (i = 0; i < FETCH_N; i++) begin
              run_access(LW, start + 4 * i, '0, 1'b0, rd);
              check("ls_rdata", rd, ref_word(start + 4 * i));
            end
          end
        join
      end
      4'h2: begin
        collect_fetch(start, 1);
        // one cycle on, the read at start + 4 holds the grant
        @(negedge CLK);
        pulse_redirect(target);
        collect_fetch(target, FETCH_N);
      end
      default: begin
        collect_fetch(start, FETCH_N);
      end
    endcase
    fetch_en = 1'b0;
    // the read still posted ends with one last pulse
    seen = 1'b0;
    cyc  = 0;
    while (!seen) begin
      @(negedge CLK);
      cyc++;
      if (instr_valid) begin
        seen = 1'b1;
      end else if (cyc >= FETCH_LIMIT) begin
        abort_run("timeout: the last posted fetch never completed");
      end
    end
  endtask

  task automatic run_case(input logic [7:0] kind, input logic [3:0] code,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [31:0] exp);
    ls_op_t      op;
    logic        misal;
    logic [31:0] model;
    logic [31:0] rd;
    logic [31:0] base;
    int          i;
    op    = ls_op_t'(code);
    misal = misaligned_addr(op, addr);
    case (kind)
      "S": begin
        if (!misal) begin
          ref_store(op, addr, wdata);
        end
        model = ref_word(addr);
        check("expected value in cases file", exp, model);
        run_access(op, addr, wdata, misal, rd);
      end
      "L": begin
        model = misal ? '0 : ref_load(op, addr);
        check("expected value in cases file", exp, model);
        run_access(op, addr, wdata, misal, rd);
        if (!misal) begin
          check("ls_rdata", rd, model);
        end
      end
      "F": begin
        base  = (code == 4'h2) ? wdata : addr;
        model = '0;
        for (i = 0; i < FETCH_N; i++) begin
          model = model ^ ref_word(base + 4 * i);
        end
        check("expected value in cases file", exp, model);
        run_fetch(code, addr, wdata);
      end
      default: begin
        abort_run($sformatf("unknown case kind '%c' in the cases file", kind));
      end
    endcase
  endtask

  initial begin
    int               fd;
    int               code;
    int               n_cases;
    int               cyc;
    int               i;
    logic [7:0]       kind;
    logic [31:0]      op_f;
    logic [31:0]      addr_f;
    logic [31:0]      wdata_f;
    logic [31:0]      exp_f;
    logic [8*160-1:0] skip;
    fetch_en    = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    ls_req      = 1'b0;
    ls_op       = LW;
    ls_addr     = '0;
    ls_wdata    = '0;
    for (i = 0; i < REF_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    cyc = 0;
    while (nRST !== 1'b1) begin
      @(negedge CLK);
      cyc++;
      if (cyc > 20) begin
        abort_run("reset was never released");
      end
    end
    fd = $fopen("verification/mem_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open verification/mem_cases.txt");
    end
    n_cases = 0;
    code    = $fscanf(fd, " %c", kind);
    while (code == 1) begin
      if (kind == "#") begin
        code = $fgets(skip, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h", op_f, addr_f, wdata_f, exp_f);
        if (code != 4) begin
          abort_run($sformatf("malformed line after case %0d in the cases file", n_cases));
        end
        n_cases++;
        run_case(kind, op_f[3:0], addr_f, wdata_f, exp_f);
      end
      code = $fscanf(fd, " %c", kind);
    end
    $fclose(fd);
    if (n_cases == 0) begin
      abort_run("the cases file held no cases");
    end else begin
      $display("Simulation finished: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: riscv_mem_subsystem.f
src/rv32_mem_pkg.sv
src/generic_bus_if.sv
src/fetch_unit.sv
src/load_store_unit.sv
src/memory_controller.sv
src/word_ram.sv
src/riscv_mem_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_riscv_mem_subsystem.sv

// File: verification/mem_cases.txt
# kind op addr wdata expected; kind S store, L load, F fetch; other columns hex
# op: 0 LB 1 LH 2 LW 4 LBU 5 LHU 8 SB 9 SH A SW; F op is mode 0 plain 1 loads 2 redirect
# S: aligned word after the store, L: load result or 0 if misaligned, F: XOR of 4 words
# word stores, then byte and halfword merges
S A 00000100 11223344 11223344
S A 00000104 8899AABB 8899AABB
S 8 00000101 000000F0 1122F044
S 9 00000106 ABCD8765 8765AABB
L 2 00000100 00000000 1122F044
L 2 00000104 00000000 8765AABB
S 8 00000103 00000080 8022F044
# byte and halfword loads at each lane
L 0 00000100 00000000 00000044
L 0 00000101 00000000 FFFFFFF0
L 0 00000102 00000000 00000022
L 0 00000103 00000000 FFFFFF80
L 4 00000100 00000000 00000044
L 4 00000101 00000000 000000F0
L 4 00000102 00000000 00000022
L 4 00000103 00000000 00000080
L 1 00000104 00000000 FFFFAABB
L 1 00000106 00000000 FFFF8765
L 5 00000104 00000000 0000AABB
L 5 00000106 00000000 00008765
# misaligned accesses leave memory alone
L 1 00000105 00000000 00000000
L 2 00000102 00000000 00000000
S 9 00000103 FFFFFFFF 8022F044
S A 00000106 FFFFFFFF 8765AABB
L 2 00000100 00000000 8022F044
L 2 00000104 00000000 8765AABB
# program words
S A 00000000 00000013 00000013
S A 00000004 00100093 00100093
S A 00000008 00200113 00200113
S A 0000000C 00308193 00308193
S A 00000010 00418213 00418213
S A 00000014 00520293 00520293
S A 00000018 00628313 00628313
S A 0000001C 00730393 00730393
S A 00000040 FE010113 FE010113
S A 00000044 00112E23 00112E23
S A 00000048 00812C23 00812C23
S A 0000004C 02010413 02010413
# fetch streams
F 0 00000000 00000000 00008000
F 1 00000010 00000000 00020000
F 2 00000000 00000040 FC900700
